// File: hdl/rv_ex_macros.svh
`ifndef RV_EX_MACROS_SVH
`define RV_EX_MACROS_SVH

// Datapath width
`define EX_XLEN 32

// Execute lanes behind the dispatcher
`define EX_NUM_LANES 4

// Result slots per lane, equal to its credits
`define EX_LANE_DEPTH 2

// Input FIFO slots, equal to upstream credits
`define EX_IN_DEPTH 4

// Downstream slots granted after reset
`define EX_OUT_CREDITS 4

`endif

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef enum logic [3:0] {
        LUI_IR,
        AUIPC_IR,
        JAL_IR,
        JALR_IR,
        BRANCH_IR,
        LOAD_IR,
        STORE_IR,
        REG_IMM_IR,
        REG_REG_IR,
        SYS_CALL_IR,
        CSR_IR
    } ir_type_e;

    // Low bits follow funct3, top bit picks SUB or SRA
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        ALU_SUB    = 4'b1000,
        ALU_CP_IN2 = 4'b1001,
        ALU_JALR   = 4'b1010,
        ALU_CSRRC  = 4'b1011,
        ALU_SRA    = 4'b1101
    } alu_op_e;

    // Conditional codes reuse funct3
    typedef enum logic [2:0] {
        BR_BEQ     = 3'b000,
        BR_BNE     = 3'b001,
        BR_JUMP    = 3'b010,
        BR_NO_JUMP = 3'b011,
        BR_BLT     = 3'b100,
        BR_BGE     = 3'b101,
        BR_BLTU    = 3'b110,
        BR_BGEU    = 3'b111
    } branch_op_e;

    localparam logic [2:0] ADD_FUNCT3  = 3'b000;
    localparam logic [2:0] SLL_FUNCT3  = 3'b001;
    localparam logic [2:0] SLT_FUNCT3  = 3'b010;
    localparam logic [2:0] SLTU_FUNCT3 = 3'b011;
    localparam logic [2:0] XOR_FUNCT3  = 3'b100;
    localparam logic [2:0] SR_FUNCT3   = 3'b101;
    localparam logic [2:0] OR_FUNCT3   = 3'b110;
    localparam logic [2:0] AND_FUNCT3  = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_view_t;

    typedef union packed {
        rv_r_view_t r;
        rv_i_view_t i;
    } rv_instr_u;

endpackage

// File: hdl/ex_flow_pkg.sv
`include "rv_ex_macros.svh"

package ex_flow_pkg;

    // Request as it arrives from operand read
    typedef struct packed {
        rv_isa_pkg::rv_instr_u instr;
        logic [`EX_XLEN-1:0]   pc;
        logic [`EX_XLEN-1:0]   data1;
        logic [`EX_XLEN-1:0]   data2;
        logic [`EX_XLEN-1:0]   z_;
    } ex_req_t;

    // Decoded micro-op, shared by all lanes
    typedef struct packed {
        rv_isa_pkg::ir_type_e ir_type;
        logic [2:0]           funct3;
        logic [6:0]           funct7;
        logic [`EX_XLEN-1:0]  data1;
        logic [`EX_XLEN-1:0]  data2;
        logic [`EX_XLEN-1:0]  pc;
        logic [`EX_XLEN-1:0]  imm;
        logic [`EX_XLEN-1:0]  z_;
    } ex_uop_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0] result;
        logic                taken;
        logic [`EX_XLEN-1:0] link;
    } ex_rsp_t;

endpackage

// File: hdl/ex_ctrl.sv
`timescale 1ns/1ps
`include "rv_ex_macros.svh"

module ex_ctrl (
    input  rv_isa_pkg::ir_type_e    ir_type,
    input  logic [2:0]              funct3,
    input  logic [6:0]              funct7,
    input  logic [`EX_XLEN-1:0]     data1,
    input  logic [`EX_XLEN-1:0]     data2,
    input  logic [`EX_XLEN-1:0]     pc,
    input  logic [`EX_XLEN-1:0]     imm,
    input  logic [`EX_XLEN-1:0]     z_,
    output logic [`EX_XLEN-1:0]     in1,
    output logic [`EX_XLEN-1:0]     in2,
    output rv_isa_pkg::branch_op_e  branch_op,
    output rv_isa_pkg::alu_op_e     alu_op
);
    import rv_isa_pkg::*;

    // Arithmetic forms share funct3; only SUB and SRA look at funct7
    function automatic alu_op_e arith_op(input ir_type_e typ, input logic [2:0] f3,
                                         input logic [6:0] f7);
        if (f3 == SR_FUNCT3) begin
            return alu_op_e'({f7[5], f3});
        end
        else if (f3 == ADD_FUNCT3 && typ == REG_REG_IR) begin
            return alu_op_e'({f7[5], f3});
        end
        else begin
            return alu_op_e'({1'b0, f3});
        end
    endfunction

    always_comb
    begin
        case (ir_type)
            LUI_IR, AUIPC_IR, JAL_IR, BRANCH_IR:
            begin
                in1 = pc;
                in2 = imm;
            end
            REG_REG_IR:
            begin
                in1 = data1;
                in2 = data2;
            end
            SYS_CALL_IR:
            begin
                in1 = z_;
                in2 = imm;
            end
            CSR_IR:
            begin
                in1 = z_;
                // Immediate forms carry zimm
                in2 = funct3[2] ? imm : data1;
            end
            default:
            begin
                in1 = data1;
                in2 = imm;
            end
        endcase
    end

    always_comb
    begin
        case (ir_type)
            JAL_IR, JALR_IR, SYS_CALL_IR: branch_op = BR_JUMP;
            BRANCH_IR:                    branch_op = branch_op_e'(funct3);
            default:                      branch_op = BR_NO_JUMP;
        endcase
    end

    always_comb
    begin
        case (ir_type)
            LUI_IR:                 alu_op = ALU_CP_IN2;
            JALR_IR:                alu_op = ALU_JALR;
            REG_REG_IR, REG_IMM_IR: alu_op = arith_op(ir_type, funct3, funct7);
            CSR_IR:
            begin
                case (funct3[1:0])
                    2'b01:   alu_op = ALU_CP_IN2;
                    2'b10:   alu_op = ALU_OR;
                    2'b11:   alu_op = ALU_CSRRC;
                    default: alu_op = ALU_ADD;
                endcase
            end
            // Address and target forms
            default:                alu_op = ALU_ADD;
        endcase
    end

endmodule

// File: hdl/ex_lane.sv
`timescale 1ns/1ps
`include "rv_ex_macros.svh"

module ex_lane (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue_valid,
    input  ex_flow_pkg::ex_uop_t issue_uop,
    output logic                 lane_credit,
    output logic                 rsp_avail,
    output ex_flow_pkg::ex_rsp_t rsp_data,
    input  logic                 pop
);
    import rv_isa_pkg::*;
    import ex_flow_pkg::*;

    localparam int PW = $clog2(`EX_LANE_DEPTH);
    localparam int CW = $clog2(`EX_LANE_DEPTH + 1);

    logic [`EX_XLEN-1:0] in1;
    logic [`EX_XLEN-1:0] in2;
    logic [`EX_XLEN-1:0] alu_out;
    branch_op_e          branch_op;
    alu_op_e             alu_op;
    logic                taken;
    ex_rsp_t             rsp_new;
    ex_rsp_t             rsp_mem [`EX_LANE_DEPTH];
    logic [PW-1:0]       wr_ptr;
    logic [PW-1:0]       rd_ptr;
    logic [CW-1:0]       count;

    ex_ctrl u_ctrl (
        .ir_type   (issue_uop.ir_type),
        .funct3    (issue_uop.funct3),
        .funct7    (issue_uop.funct7),
        .data1     (issue_uop.data1),
        .data2     (issue_uop.data2),
        .pc        (issue_uop.pc),
        .imm       (issue_uop.imm),
        .z_        (issue_uop.z_),
        .in1       (in1),
        .in2       (in2),
        .branch_op (branch_op),
        .alu_op    (alu_op)
    );

    always_comb
    begin
        case (alu_op)
            ALU_SUB:    alu_out = in1 - in2;
            ALU_SLL:    alu_out = in1 << in2[4:0];
            ALU_SLT:    alu_out = {{(`EX_XLEN-1){1'b0}}, $signed(in1) < $signed(in2)};
            ALU_SLTU:   alu_out = {{(`EX_XLEN-1){1'b0}}, in1 < in2};
            ALU_XOR:    alu_out = in1 ^ in2;
            ALU_SRL:    alu_out = in1 >> in2[4:0];
            ALU_SRA:    alu_out = $signed(in1) >>> in2[4:0];
            ALU_OR:     alu_out = in1 | in2;
            ALU_AND:    alu_out = in1 & in2;
            ALU_CP_IN2: alu_out = in2;
            ALU_JALR:   alu_out = (in1 + in2) & ~`EX_XLEN'd1;
            ALU_CSRRC:  alu_out = in1 & ~in2;
            default:    alu_out = in1 + in2;
        endcase
    end

    // Branch decision on the register operands
    always_comb
    begin
        case (branch_op)
            BR_BEQ:  taken = issue_uop.data1 == issue_uop.data2;
            BR_BNE:  taken = issue_uop.data1 != issue_uop.data2;
            BR_BLT:  taken = $signed(issue_uop.data1) < $signed(issue_uop.data2);
            BR_BGE:  taken = $signed(issue_uop.data1) >= $signed(issue_uop.data2);
            BR_BLTU: taken = issue_uop.data1 < issue_uop.data2;
            BR_BGEU: taken = issue_uop.data1 >= issue_uop.data2;
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign rsp_new = '{result: alu_out, taken: taken, link: issue_uop.pc + `EX_XLEN'd4};

    always_ff @(posedge clk)
    begin
        if (issue_valid)
            rsp_mem[wr_ptr] <= rsp_new;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (issue_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({issue_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign rsp_avail   = count != '0;
    assign rsp_data    = rsp_mem[rd_ptr];
    // Slot freed by the pop goes back as a credit
    assign lane_credit = pop;

    a_push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> count < CW'(`EX_LANE_DEPTH));

    a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> rsp_avail);

endmodule

// File: hdl/ex_dispatch.sv
`timescale 1ns/1ps
`include "rv_ex_macros.svh"

module ex_dispatch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  ex_flow_pkg::ex_req_t      in_req,
    output logic                      in_credit,
    output logic [`EX_NUM_LANES-1:0]  issue_valid,
    output ex_flow_pkg::ex_uop_t      issue_uop,
    input  logic [`EX_NUM_LANES-1:0]  lane_credit
);
    import rv_isa_pkg::*;
    import ex_flow_pkg::*;

    localparam int IPW = $clog2(`EX_IN_DEPTH);
    localparam int ICW = $clog2(`EX_IN_DEPTH + 1);
    localparam int LCW = $clog2(`EX_LANE_DEPTH + 1);
    localparam int LNW = $clog2(`EX_NUM_LANES);

    ex_req_t             in_mem [`EX_IN_DEPTH];
    logic [IPW-1:0]      in_wr_ptr;
    logic [IPW-1:0]      in_rd_ptr;
    logic [ICW-1:0]      in_cnt;
    ex_req_t             head;
    rv_instr_u           instr;
    ir_type_e            dec_type;
    logic [`EX_XLEN-1:0] imm;
    logic [LCW-1:0]      lane_cnt [`EX_NUM_LANES];
    logic [LNW-1:0]      next_lane;
    logic                issue;

    always_ff @(posedge clk)
    begin
        if (in_valid)
            in_mem[in_wr_ptr] <= in_req;
    end

    assign head  = in_mem[in_rd_ptr];
    assign instr = head.instr;

    always_comb
    begin
        case (instr.r.opcode)
            7'b0110111: dec_type = LUI_IR;
            7'b0010111: dec_type = AUIPC_IR;
            7'b1101111: dec_type = JAL_IR;
            7'b1100111: dec_type = JALR_IR;
            7'b1100011: dec_type = BRANCH_IR;
            7'b0000011: dec_type = LOAD_IR;
            7'b0100011: dec_type = STORE_IR;
            7'b0110011: dec_type = REG_REG_IR;
            7'b1110011: dec_type = (instr.r.funct3 == 3'b000) ? SYS_CALL_IR : CSR_IR;
            default:    dec_type = REG_IMM_IR;
        endcase
    end

    // S, B, U and J immediates rebuilt from the R view
    always_comb
    begin
        case (dec_type)
            LUI_IR, AUIPC_IR:
                imm = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};
            JAL_IR:
                imm = {{(`EX_XLEN-20){instr.r.funct7[6]}}, instr.r.rs1, instr.r.funct3,
                       instr.r.rs2[0], instr.r.funct7[5:0], instr.r.rs2[4:1], 1'b0};
            BRANCH_IR:
                imm = {{(`EX_XLEN-12){instr.r.funct7[6]}}, instr.r.rd[0],
                       instr.r.funct7[5:0], instr.r.rd[4:1], 1'b0};
            STORE_IR:
                imm = {{(`EX_XLEN-12){instr.r.funct7[6]}}, instr.r.funct7, instr.r.rd};
            CSR_IR:
                imm = {{(`EX_XLEN-5){1'b0}}, instr.i.rs1};
            default:
                imm = {{(`EX_XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
        endcase
    end

    assign issue_uop = '{ir_type: dec_type, funct3: instr.r.funct3, funct7: instr.r.funct7,
                         data1: head.data1, data2: head.data2, pc: head.pc, imm: imm,
                         z_: head.z_};

    assign issue     = (in_cnt != '0) && (lane_cnt[next_lane] != '0);
    assign in_credit = issue;

    always_comb
    begin
        for (int k = 0; k < `EX_NUM_LANES; k++)
            issue_valid[k] = issue && (next_lane == LNW'(k));
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_wr_ptr <= '0;
            in_rd_ptr <= '0;
            in_cnt    <= '0;
            next_lane <= '0;
            for (int k = 0; k < `EX_NUM_LANES; k++)
                lane_cnt[k] <= LCW'(`EX_LANE_DEPTH);
        end
        else
        begin
            if (in_valid)
                in_wr_ptr <= in_wr_ptr + 1'b1;
            if (issue)
            begin
                in_rd_ptr <= in_rd_ptr + 1'b1;
                next_lane <= (next_lane == LNW'(`EX_NUM_LANES - 1)) ? '0 : next_lane + 1'b1;
            end
            case ({in_valid, issue})
                2'b10:   in_cnt <= in_cnt + 1'b1;
                2'b01:   in_cnt <= in_cnt - 1'b1;
                default: in_cnt <= in_cnt;
            endcase
            for (int k = 0; k < `EX_NUM_LANES; k++)
            begin
                case ({issue_valid[k], lane_credit[k]})
                    2'b10:   lane_cnt[k] <= lane_cnt[k] - 1'b1;
                    2'b01:   lane_cnt[k] <= lane_cnt[k] + 1'b1;
                    default: lane_cnt[k] <= lane_cnt[k];
                endcase
            end
        end
    end

    // Lane credits stay within the lane buffer depth
    for (genvar k = 0; k < `EX_NUM_LANES; k++)
    begin : g_credit_chk
        a_lane_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
            lane_cnt[k] <= LCW'(`EX_LANE_DEPTH));
    end

    a_fifo_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> in_cnt < ICW'(`EX_IN_DEPTH));

endmodule

// File: hdl/ex_collect.sv
`timescale 1ns/1ps
`include "rv_ex_macros.svh"

module ex_collect (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [`EX_NUM_LANES-1:0]                rsp_avail,
    input  ex_flow_pkg::ex_rsp_t [`EX_NUM_LANES-1:0] rsp_data,
    output logic [`EX_NUM_LANES-1:0]                pop,
    output logic                                    out_valid,
    output ex_flow_pkg::ex_rsp_t                    out_rsp,
    input  logic                                    out_credit
);
    localparam int OCW = $clog2(`EX_OUT_CREDITS + 1);
    localparam int LNW = $clog2(`EX_NUM_LANES);

    logic [OCW-1:0] out_cnt;
    logic [LNW-1:0] next_rd;
    logic           take;

    // Same rotation as the dispatcher keeps program order
    assign take = rsp_avail[next_rd] && (out_cnt != '0);

    always_comb
    begin
        for (int k = 0; k < `EX_NUM_LANES; k++)
            pop[k] = take && (next_rd == LNW'(k));
    end

    always_ff @(posedge clk)
    begin
        if (take)
            out_rsp <= rsp_data[next_rd];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            next_rd   <= '0;
            out_cnt   <= OCW'(`EX_OUT_CREDITS);
        end
        else
        begin
            out_valid <= take;
            if (take)
                next_rd <= (next_rd == LNW'(`EX_NUM_LANES - 1)) ? '0 : next_rd + 1'b1;
            case ({take, out_credit})
                2'b10:   out_cnt <= out_cnt - 1'b1;
                2'b01:   out_cnt <= out_cnt + 1'b1;
                default: out_cnt <= out_cnt;
            endcase
        end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        out_cnt <= OCW'(`EX_OUT_CREDITS));

endmodule

// File: hdl/ex_top.sv
`timescale 1ns/1ps
`include "rv_ex_macros.svh"

module ex_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  ex_flow_pkg::ex_req_t in_req,
    output logic                 in_credit,
    output logic                 out_valid,
    output ex_flow_pkg::ex_rsp_t out_rsp,
    input  logic                 out_credit
);
    import ex_flow_pkg::*;

    logic [`EX_NUM_LANES-1:0]    issue_valid;
    ex_uop_t                     issue_uop;
    logic [`EX_NUM_LANES-1:0]    lane_credit;
    logic [`EX_NUM_LANES-1:0]    rsp_avail;
    ex_rsp_t [`EX_NUM_LANES-1:0] rsp_data;
    logic [`EX_NUM_LANES-1:0]    pop;

    ex_dispatch u_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_req      (in_req),
        .in_credit   (in_credit),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop),
        .lane_credit (lane_credit)
    );

    for (genvar k = 0; k < `EX_NUM_LANES; k++)
    begin : g_lane
        ex_lane u_lane (
            .clk         (clk),
            .rst_n       (rst_n),
            .issue_valid (issue_valid[k]),
            .issue_uop   (issue_uop),
            .lane_credit (lane_credit[k]),
            .rsp_avail   (rsp_avail[k]),
            .rsp_data    (rsp_data[k]),
            .pop         (pop[k])
        );
    end

    ex_collect u_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .rsp_avail  (rsp_avail),
        .rsp_data   (rsp_data),
        .pop        (pop),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp),
        .out_credit (out_credit)
    );

endmodule

// File: verification/ex_tb.sv
`timescale 1ns/1ps
`include "rv_ex_macros.svh"

module ex_tb;
    import ex_flow_pkg::*;

    localparam int NUM_VEC    = 30;
    localparam int FIELDS     = 8;
    localparam int WAIT_LIMIT = 500;
    localparam logic [31:0] SEED = 32'd79566;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    ex_req_t     in_req;
    logic        in_credit;
    logic        out_valid;
    ex_rsp_t     out_rsp;
    logic        out_credit = 1'b0;

    // Per vector: instr, pc, data1, data2, z_, result, taken, link
    logic [31:0] golden [NUM_VEC*FIELDS];
    logic [31:0] prod_lfsr;
    logic [31:0] cons_lfsr;
    int          credit_returns;
    int          in_mon;
    int          sent;
    int          received;
    int          outstanding;
    int          cycle;
    int          due_q[$];
    int          errors = 0;
    int          checks = 0;

    ex_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp),
        .out_credit (out_credit)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int nbits, output int val);
        val = 0;
        for (int b = 0; b < nbits; b++)
        begin
            state = lfsr_next(state);
            val = (val << 1) | int'(state[0]);
        end
    endtask

    task automatic finish_run();
        $display("checks=%0d errors=%0d sent=%0d received=%0d", checks, errors, sent, received);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    endtask

    // Input credit bookkeeping, independent of the producer
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_mon         <= `EX_IN_DEPTH;
            credit_returns <= 0;
        end
        else
        begin
            if (in_valid && in_mon == 0)
            begin
                $display("in_valid was sent without an input credit at %0t", $time);
                errors++;
            end
            if (in_mon + int'(in_credit) - int'(in_valid) > `EX_IN_DEPTH)
            begin
                $display("in_credit returned more credits than were used at %0t", $time);
                errors++;
            end
            in_mon <= in_mon + int'(in_credit) - int'(in_valid);
            if (in_credit)
                credit_returns <= credit_returns + 1;
        end
    end

    task automatic send_vectors(output bit ok);
        int gap;
        int waited;
        int base;
        ok = 1'b1;
        for (int v = 0; v < NUM_VEC && ok; v++)
        begin
            base = v * FIELDS;
            // Mostly back to back, now and then a short idle gap
            draw_bits(prod_lfsr, 3, gap);
            gap = (gap > 4) ? gap - 4 : 0;
            for (int i = 0; i < gap; i++)
            begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            waited = 0;
            while (`EX_IN_DEPTH + credit_returns - sent == 0 && waited < WAIT_LIMIT)
            begin
                in_valid <= 1'b0;
                @(posedge clk);
                waited++;
            end
            if (`EX_IN_DEPTH + credit_returns - sent == 0)
            begin
                $display("Timed out waiting for an input credit for vector %0d", v);
                errors++;
                ok = 1'b0;
            end
            else
            begin
                in_valid <= 1'b1;
                in_req   <= {golden[base], golden[base+1], golden[base+2], golden[base+3],
                             golden[base+4]};
                sent++;
                @(posedge clk);
            end
        end
        in_valid <= 1'b0;
    endtask

    // Consumer with 0 to 7 cycles of credit delay
    always @(posedge clk or negedge rst_n)
    begin : consumer
        int delay;
        int base;
        int slot;
        if (!rst_n)
        begin
            out_credit  <= 1'b0;
            received    <= 0;
            outstanding = 0;
            cycle       = 0;
            cons_lfsr   = SEED;
            due_q.delete();
        end
        else
        begin
            cycle = cycle + 1;
            slot  = -1;
            for (int k = 0; k < due_q.size(); k++)
                if (slot < 0 && due_q[k] <= cycle)
                    slot = k;
            if (slot >= 0)
            begin
                due_q.delete(slot);
                out_credit  <= 1'b1;
                outstanding = outstanding - 1;
            end
            else
                out_credit <= 1'b0;

            if (out_valid)
            begin
                base = received * FIELDS;
                if (outstanding >= `EX_OUT_CREDITS)
                begin
                    $display("More than %0d results outstanding at %0t", `EX_OUT_CREDITS, $time);
                    errors++;
                end
                if (received >= NUM_VEC)
                begin
                    $display("Unexpected result after the last vector at %0t", $time);
                    errors++;
                end
                else
                begin
                    checks++;
                    if (out_rsp.result !== golden[base+5])
                    begin
                        $display("ERR %0t: vector %0d result %h, expected %h", $time, received,
                                 out_rsp.result, golden[base+5]);
                        errors++;
                    end
                    if (out_rsp.taken !== golden[base+6][0])
                    begin
                        $display("ERR %0t: vector %0d taken %b, expected %b", $time, received,
                                 out_rsp.taken, golden[base+6][0]);
                        errors++;
                    end
                    if (out_rsp.link !== golden[base+7])
                    begin
                        $display("ERR %0t: vector %0d link %h, expected %h", $time, received,
                                 out_rsp.link, golden[base+7]);
                        errors++;
                    end
                end
                outstanding = outstanding + 1;
                draw_bits(cons_lfsr, 3, delay);
                due_q.push_back(cycle + delay);
                received <= received + 1;
            end
        end
    end

    initial
    begin
        bit ok;
        int waited;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        sent      = 0;
        prod_lfsr = SEED;
        $readmemh("verification/ex_golden.txt", golden);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if ($isunknown(golden[NUM_VEC*FIELDS-1]))
        begin
            $display("Golden file is missing or holds fewer than %0d vectors", NUM_VEC);
            errors++;
        end
        else
        begin
            send_vectors(ok);
            if (ok)
            begin
                waited = 0;
                while (received < NUM_VEC && waited < WAIT_LIMIT)
                begin
                    @(posedge clk);
                    waited++;
                end
                if (received < NUM_VEC)
                begin
                    $display("Timed out with %0d of %0d results received", received, NUM_VEC);
                    errors++;
                end
                else if (in_mon != `EX_IN_DEPTH)
                begin
                    $display("Input credits were not all returned, %0d held", in_mon);
                    errors++;
                end
            end
        end
        finish_run();
    end

endmodule

// File: verification/ex_golden.txt
// instr    pc       data1    data2    z_       | expected: result  taken  link
// One vector per line, hex, results leave in this order
003100B3 00001000 00000005 00000007 00000000 0000000C 0 00001004
403100B3 00001004 00000005 00000007 00000000 FFFFFFFE 0 00001008
003110B3 00001008 00000003 00000024 00000000 00000030 0 0000100C
003120B3 0000100C FFFFFFFF 00000001 00000000 00000001 0 00001010
003130B3 00001010 FFFFFFFF 00000001 00000000 00000000 0 00001014
003140B3 00001014 F0F0F0F0 0FF00FF0 00000000 FF00FF00 0 00001018
003150B3 00001018 80000000 00000004 00000000 08000000 0 0000101C
403150B3 0000101C 80000000 00000004 00000000 F8000000 0 00001020
003170B3 00001020 FF00FF00 0FF00FF0 00000000 0F000F00 0 00001024
FFF10093 00001024 00000010 12345678 00000000 0000000F 0 00001028
40815093 00001028 F0000000 00000000 00000000 FFF00000 0 0000102C
123450B7 0000102C 00000000 00000000 00000000 12345000 0 00001030
00001097 00001030 00000000 00000000 00000000 00002030 0 00001034
010000EF 00001034 00000000 00000000 00000000 00001044 1 00001038
FF9FF0EF 00001038 00000000 00000000 00000000 00001030 1 0000103C
005100E7 0000103C 00002000 00000000 00000000 00002004 1 00001040
00310463 00001040 00000042 00000042 00000000 00001048 1 00001044
00311463 00001044 00000042 00000042 00000000 0000104C 0 00001048
00314463 00001048 FFFFFFFE 00000001 00000000 00001050 1 0000104C
00315463 0000104C FFFFFFFE 00000001 00000000 00001054 0 00001050
00316463 00001050 FFFFFFFE 00000001 00000000 00001058 0 00001054
00317463 00001054 FFFFFFFE 00000001 00000000 0000105C 1 00001058
FFC12083 00001058 00003000 00000000 00000000 00002FFC 0 0000105C
FE312823 0000105C 00003000 00000055 00000000 00002FF0 0 00001060
300110F3 00001060 12345678 00000000 0000AAAA 12345678 0 00001064
300120F3 00001064 0000000F 00000000 0000F000 0000F00F 0 00001068
300130F3 00001068 000000F0 00000000 0000FFFF 0000FF0F 0 0000106C
300AD0F3 0000106C FFFFFFFF 00000000 0000AAAA 00000015 0 00001070
3001E0F3 00001070 FFFFFFFF 00000000 00000100 00000103 0 00001074
300FF0F3 00001074 00000000 00000000 FFFFFFFF FFFFFFE0 0 00001078

// File: project.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/ex_flow_pkg.sv
hdl/ex_ctrl.sv
hdl/ex_lane.sv
hdl/ex_dispatch.sv
hdl/ex_collect.sv
hdl/ex_top.sv
verification/ex_tb.sv
